// File: hdl/hydra_pkg.sv
package hydra_pkg;

    localparam int N_PORTS       = 4;
    localparam int DATA_W        = 16;
    localparam int N_PRIOR       = 4;
    localparam int BANK_SLOTS    = 4;
    localparam int MAX_PKT_WORDS = 16;
    localparam int QUEUE_DEPTH   = 8;

    localparam int HDR_DEST_LSB  = 0;   // header word bits 1:0
    localparam int HDR_PRIOR_LSB = 2;   // header word bits 3:2, higher is more urgent

    typedef logic [1:0] port_t;
    typedef logic [1:0] prior_t;
    typedef logic [1:0] slot_t;
    typedef logic [4:0] len_t;          // up to MAX_PKT_WORDS

    typedef struct packed {
        port_t  bank;                   // source bank
        slot_t  slot;
        port_t  dest;
        prior_t prior;
        len_t   len;
    } desc_t;

    typedef struct packed {
        logic              vld;
        logic              sop;
        logic              eop;
        port_t             port;        // output port the bank is serving
        logic [DATA_W-1:0] data;
    } bank_rd_t;

    typedef struct packed {
        logic  vld;
        desc_t desc;
    } enq_t;

endpackage

// File: hdl/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
    parameter int  DEPTH     = 8,
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            push_ok;
    logic            pop_ok;

    assign empty   = (count == '0);
    assign push_ok = push && (count != CW'(DEPTH));   // a push into a full FIFO is dropped
    assign pop_ok  = pop && !empty;
    assign head    = mem[rd_ptr];                    // head is visible before the pop

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(push_ok) - CW'(pop_ok);
        end
    end

endmodule

// File: hdl/rd_req_if.sv
`timescale 1ns/100ps

interface rd_req_if;
    import hydra_pkg::*;

    logic  req;     // held until the first word of the packet comes back
    port_t bank;
    slot_t slot;
    len_t  len;

    modport requester (
        output req, bank, slot, len
    );

    modport server (
        input req, bank, slot, len
    );

endinterface

// File: hdl/packet_bank.sv
`timescale 1ns/100ps

module packet_bank #(
    parameter hydra_pkg::port_t BANK_IDX   = '0,
    parameter int               BANK_SLOTS = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         wr_sop,
    input  logic                         wr_eop,
    input  logic                         wr_vld,
    input  logic [hydra_pkg::DATA_W-1:0] wr_data,
    output logic                         pause,
    output logic                         join_push,
    output hydra_pkg::desc_t             join_head,
    input  logic                         join_ack,
    rd_req_if.server                     rd_req [hydra_pkg::N_PORTS],
    output hydra_pkg::bank_rd_t          rd_out
);
    import hydra_pkg::*;

    localparam int OFF_W = $clog2(MAX_PKT_WORDS);

    logic [DATA_W-1:0]     mem [BANK_SLOTS*MAX_PKT_WORDS];
    logic [BANK_SLOTS-1:0] slot_free;
    slot_t                 free_idx;
    slot_t                 cur_slot;
    len_t                  wr_cnt;
    port_t                 dest_r;
    prior_t                prior_r;
    slot_t                 wr_slot;
    logic [OFF_W-1:0]      wr_off;
    port_t                 hdr_dest;
    prior_t                hdr_prior;
    desc_t                 desc_r;
    logic [N_PORTS-1:0]    req_hit;
    slot_t                 req_slot [N_PORTS];
    len_t                  req_len [N_PORTS];
    logic [N_PORTS-1:0]    rr_mask;
    logic [N_PORTS-1:0]    eligible;
    logic [N_PORTS-1:0]    cand;
    logic [N_PORTS-1:0]    gnt_oh;
    port_t                 gnt;
    logic                  rd_busy;              // also the valid flag of rd_out
    slot_t                 rd_slot;
    len_t                  rd_len;
    len_t                  rd_cnt;               // index of the next word to stream
    port_t                 rd_port_r;
    logic                  rd_sop_r;
    logic                  rd_eop_r;
    logic [DATA_W-1:0]     rd_data_r;

    assign pause = ~|slot_free;

    always_comb begin
        free_idx = '0;
        for (int s = BANK_SLOTS - 1; s >= 0; s--) begin
            if (slot_free[s]) free_idx = slot_t'(s);   // lowest free slot wins
        end
    end

    assign wr_slot   = wr_sop ? free_idx : cur_slot;
    assign wr_off    = wr_sop ? '0 : wr_cnt[OFF_W-1:0];
    assign hdr_dest  = wr_sop ? wr_data[HDR_DEST_LSB +: $bits(port_t)] : dest_r;
    assign hdr_prior = wr_sop ? wr_data[HDR_PRIOR_LSB +: $bits(prior_t)] : prior_r;

    always_ff @(posedge clk) begin
        if (wr_vld) begin
            mem[{wr_slot, wr_off}] <= wr_data;
        end
        if (wr_vld && wr_eop) begin
            desc_r <= '{bank: BANK_IDX, slot: wr_slot, dest: hdr_dest, prior: hdr_prior,
                        len: len_t'(wr_off) + len_t'(1)};
        end
        if (wr_vld && wr_sop) begin
            dest_r  <= hdr_dest;
            prior_r <= hdr_prior;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cur_slot  <= '0;
            wr_cnt    <= '0;
            join_push <= 1'b0;
        end else begin
            join_push <= wr_vld && wr_eop;           // pulse one cycle after the eop word
            if (wr_vld) begin
                cur_slot <= wr_slot;
                wr_cnt   <= len_t'(wr_off) + len_t'(1);
            end
        end
    end

    // claim at sop, release once the last word has left
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_free <= '1;
        end else begin
            if (wr_vld && wr_sop) slot_free[free_idx] <= 1'b0;
            if (rd_busy && rd_eop_r) slot_free[rd_slot] <= 1'b1;
        end
    end

    sync_fifo #(
        .DEPTH     (BANK_SLOTS),
        .payload_t (desc_t)
    ) join_fifo_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (join_push),
        .push_data (desc_r),
        .pop       (join_ack),
        .head      (join_head),
        .empty     ()
    );

    for (genvar p = 0; p < N_PORTS; p++) begin : g_req
        assign req_hit[p]  = rd_req[p].req && (rd_req[p].bank == BANK_IDX);
        assign req_slot[p] = rd_req[p].slot;
        assign req_len[p]  = rd_req[p].len;
    end

    assign eligible = req_hit & rr_mask;
    assign cand     = (|eligible) ? eligible : req_hit;   // mask exhausted, start a new round

    always_comb begin
        gnt = '0;
        for (int p = N_PORTS - 1; p >= 0; p--) begin
            if (cand[p]) gnt = port_t'(p);
        end
    end

    assign gnt_oh = N_PORTS'(1) << gnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_busy  <= 1'b0;
            rd_sop_r <= 1'b0;
            rd_eop_r <= 1'b0;
            rr_mask  <= '1;
        end else if (rd_busy) begin
            rd_sop_r <= 1'b0;
            if (rd_eop_r) begin
                rd_busy  <= 1'b0;
                rd_eop_r <= 1'b0;
            end else begin
                rd_eop_r <= (rd_cnt == rd_len - len_t'(1));
                rd_cnt   <= rd_cnt + len_t'(1);
            end
        end else if (|req_hit) begin
            rd_busy   <= 1'b1;                       // first word goes out on the next cycle
            rd_sop_r  <= 1'b1;
            rd_eop_r  <= (req_len[gnt] == len_t'(1));
            rd_slot   <= req_slot[gnt];
            rd_len    <= req_len[gnt];
            rd_cnt    <= len_t'(1);
            rd_port_r <= gnt;
            rr_mask   <= ((|eligible) ? rr_mask : '1) & ~gnt_oh;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_busy) begin
            rd_data_r <= mem[{rd_slot, rd_cnt[OFF_W-1:0]}];
        end else begin
            rd_data_r <= mem[{req_slot[gnt], {OFF_W{1'b0}}}];
        end
    end

    assign rd_out = {rd_busy, rd_sop_r, rd_eop_r, rd_port_r, rd_data_r};

endmodule

// File: hdl/join_sequencer.sv
`timescale 1ns/100ps

module join_sequencer #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [hydra_pkg::N_PORTS-1:0] join_push,
    input  hydra_pkg::desc_t              join_head [hydra_pkg::N_PORTS],
    output logic [hydra_pkg::N_PORTS-1:0] join_ack,
    output hydra_pkg::enq_t               enq
);
    import hydra_pkg::*;

    typedef logic [N_PORTS-1:0] mask_t;

    mask_t head_mask;                        // banks that pushed in one cycle
    mask_t served;
    mask_t cur;
    mask_t sel_oh;
    logic  mask_empty;
    logic  last;
    port_t sel;
    logic  enq_vld;
    desc_t enq_desc;

    sync_fifo #(
        .DEPTH     (QUEUE_DEPTH),
        .payload_t (mask_t)
    ) mask_fifo_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (|join_push),
        .push_data (join_push),
        .pop       (!mask_empty && last),
        .head      (head_mask),
        .empty     (mask_empty)
    );

    assign cur = head_mask & ~served;

    always_comb begin
        sel = '0;
        for (int b = N_PORTS - 1; b >= 0; b--) begin
            if (cur[b]) sel = port_t'(b);    // same cycle arrivals go lowest bank first
        end
    end

    assign sel_oh   = N_PORTS'(1) << sel;
    assign last     = ((cur & ~sel_oh) == '0);
    assign join_ack = mask_empty ? '0 : sel_oh;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            served  <= '0;
            enq_vld <= 1'b0;
        end else begin
            enq_vld <= !mask_empty;
            if (!mask_empty) begin
                served <= last ? '0 : (served | sel_oh);
            end
        end
    end

    always_ff @(posedge clk) begin
        enq_desc <= join_head[sel];
    end

    assign enq = {enq_vld, enq_desc};

endmodule

// File: hdl/output_port.sv
`timescale 1ns/100ps

module output_port #(
    parameter hydra_pkg::port_t PORT_IDX    = '0,
    parameter int               QUEUE_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  hydra_pkg::enq_t              enq,
    rd_req_if.requester                  rd_req,
    input  hydra_pkg::bank_rd_t          bank_words [hydra_pkg::N_PORTS],
    input  logic                         ready,
    output logic                         rd_sop,
    output logic                         rd_eop,
    output logic                         rd_vld,
    output logic [hydra_pkg::DATA_W-1:0] rd_data
);
    import hydra_pkg::*;

    desc_t              q_head [N_PRIOR];
    logic [N_PRIOR-1:0] q_empty;
    logic [N_PRIOR-1:0] q_push;
    logic [N_PRIOR-1:0] q_pop;
    prior_t             sel;
    logic               start;
    logic               busy;              // from start until the eop word returns
    bank_rd_t           ret;

    for (genvar p = 0; p < N_PRIOR; p++) begin : g_queue
        assign q_push[p] = enq.vld && (enq.desc.dest == PORT_IDX) &&
                           (enq.desc.prior == prior_t'(p));
        assign q_pop[p]  = start && (sel == prior_t'(p));

        sync_fifo #(
            .DEPTH     (QUEUE_DEPTH),
            .payload_t (desc_t)
        ) prior_fifo_inst (
            .clk       (clk),
            .rst_n     (rst_n),
            .push      (q_push[p]),
            .push_data (enq.desc),
            .pop       (q_pop[p]),
            .head      (q_head[p]),
            .empty     (q_empty[p])
        );
    end

    // strict priority, highest non-empty level
    always_comb begin
        sel = '0;
        for (int p = 0; p < N_PRIOR; p++) begin
            if (!q_empty[p]) sel = prior_t'(p);
        end
    end

    assign start = ready && !busy && !(&q_empty);   // ready only matters here

    always_comb begin
        ret = '0;
        for (int b = 0; b < N_PORTS; b++) begin
            if (bank_words[b].vld && bank_words[b].port == PORT_IDX) ret = bank_words[b];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            rd_req.req <= 1'b0;
        end else if (start) begin
            busy        <= 1'b1;
            rd_req.req  <= 1'b1;
            rd_req.bank <= q_head[sel].bank;
            rd_req.slot <= q_head[sel].slot;
            rd_req.len  <= q_head[sel].len;
        end else if (ret.vld) begin
            if (ret.sop) rd_req.req <= 1'b0;    // bank has taken the request
            if (ret.eop) busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_vld <= 1'b0;
            rd_sop <= 1'b0;
            rd_eop <= 1'b0;
        end else begin
            rd_vld <= ret.vld;
            rd_sop <= ret.vld && ret.sop;
            rd_eop <= ret.vld && ret.eop;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= ret.data;
    end

endmodule

// File: hdl/hydra.sv
`timescale 1ns/100ps

module hydra (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic [hydra_pkg::N_PORTS-1:0]                         wr_sop,
    input  logic [hydra_pkg::N_PORTS-1:0]                         wr_eop,
    input  logic [hydra_pkg::N_PORTS-1:0]                         wr_vld,
    input  logic [hydra_pkg::N_PORTS-1:0][hydra_pkg::DATA_W-1:0]  wr_data,
    output logic [hydra_pkg::N_PORTS-1:0]                         pause,
    input  logic [hydra_pkg::N_PORTS-1:0]                         ready,
    output logic [hydra_pkg::N_PORTS-1:0]                         rd_sop,
    output logic [hydra_pkg::N_PORTS-1:0]                         rd_eop,
    output logic [hydra_pkg::N_PORTS-1:0]                         rd_vld,
    output logic [hydra_pkg::N_PORTS-1:0][hydra_pkg::DATA_W-1:0]  rd_data
);
    import hydra_pkg::*;

    logic [N_PORTS-1:0] join_push;
    logic [N_PORTS-1:0] join_ack;
    desc_t              join_head [N_PORTS];
    bank_rd_t           bank_words [N_PORTS];   // every bank's return word, seen by all outputs
    enq_t               enq;

    rd_req_if rd_req [N_PORTS] ();

    for (genvar g = 0; g < N_PORTS; g++) begin : g_port
        packet_bank #(
            .BANK_IDX   (port_t'(g)),
            .BANK_SLOTS (BANK_SLOTS)
        ) bank_inst (
            .clk       (clk),
            .rst_n     (rst_n),
            .wr_sop    (wr_sop[g]),
            .wr_eop    (wr_eop[g]),
            .wr_vld    (wr_vld[g]),
            .wr_data   (wr_data[g]),
            .pause     (pause[g]),
            .join_push (join_push[g]),
            .join_head (join_head[g]),
            .join_ack  (join_ack[g]),
            .rd_req    (rd_req),
            .rd_out    (bank_words[g])
        );

        output_port #(
            .PORT_IDX    (port_t'(g)),
            .QUEUE_DEPTH (QUEUE_DEPTH)
        ) out_inst (
            .clk        (clk),
            .rst_n      (rst_n),
            .enq        (enq),
            .rd_req     (rd_req[g]),
            .bank_words (bank_words),
            .ready      (ready[g]),
            .rd_sop     (rd_sop[g]),
            .rd_eop     (rd_eop[g]),
            .rd_vld     (rd_vld[g]),
            .rd_data    (rd_data[g])
        );
    end

    join_sequencer #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) seq_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .join_push (join_push),
        .join_head (join_head),
        .join_ack  (join_ack),
        .enq       (enq)
    );

endmodule

// File: sim/hydra_props.sv
`timescale 1ns/100ps

module hydra_props (
    input logic                          clk,
    input logic                          rst_n,
    input logic [hydra_pkg::N_PORTS-1:0] rd_sop,
    input logic [hydra_pkg::N_PORTS-1:0] rd_eop,
    input logic [hydra_pkg::N_PORTS-1:0] rd_vld
);
    import hydra_pkg::*;

    logic [N_PORTS-1:0] open_pkt;   // between rd_sop and rd_eop

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            open_pkt <= '0;
        end else begin
            open_pkt <= (open_pkt | (rd_vld & rd_sop)) & ~(rd_vld & rd_eop);
        end
    end

    for (genvar p = 0; p < N_PORTS; p++) begin : g_port
        sop_has_vld: assert property (@(posedge clk) disable iff (!rst_n)
            rd_sop[p] |-> rd_vld[p])
            else $error("rd_sop without rd_vld on port %0d", p);

        eop_has_vld: assert property (@(posedge clk) disable iff (!rst_n)
            rd_eop[p] |-> rd_vld[p])
            else $error("rd_eop without rd_vld on port %0d", p);

        one_sop: assert property (@(posedge clk) disable iff (!rst_n)
            rd_sop[p] |-> !open_pkt[p])
            else $error("second rd_sop before rd_eop on port %0d", p);
    end

endmodule

bind hydra hydra_props props_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .rd_sop (rd_sop),
    .rd_eop (rd_eop),
    .rd_vld (rd_vld)
);

// File: sim/hydra_tb.sv
`timescale 1ns/100ps

module hydra_tb;
    import hydra_pkg::*;

    localparam int CLK_HALF      = 20;
    localparam int WAIT_LIMIT    = 400;

    logic                           clk;
    logic                           rst_n;
    logic [N_PORTS-1:0]             wr_sop;
    logic [N_PORTS-1:0]             wr_eop;
    logic [N_PORTS-1:0]             wr_vld;
    logic [N_PORTS-1:0][DATA_W-1:0] wr_data;
    logic [N_PORTS-1:0]             pause;
    logic [N_PORTS-1:0]             ready;
    logic [N_PORTS-1:0]             rd_sop;
    logic [N_PORTS-1:0]             rd_eop;
    logic [N_PORTS-1:0]             rd_vld;
    logic [N_PORTS-1:0][DATA_W-1:0] rd_data;

    logic [DATA_W-1:0] pkt_buf   [N_PORTS][$];   // packet being built, per input
    logic [DATA_W-1:0] exp_words [N_PORTS][$];   // expected output, per output
    int                exp_lens  [N_PORTS][$];
    logic [DATA_W-1:0] rx_words  [N_PORTS][$];
    int                rx_lens   [N_PORTS][$];
    bit                in_pkt    [N_PORTS];
    int                cur_len   [N_PORTS];
    int                enq_seen  [N_PORTS];      // enqueues issued by the sequencer, per output
    int                enq_want  [N_PORTS];      // packets sent so far, per output
    int                errors;
    int                tests_run;
    int                tests_ok;

    hydra hydra_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_sop  (wr_sop),
        .wr_eop  (wr_eop),
        .wr_vld  (wr_vld),
        .wr_data (wr_data),
        .pause   (pause),
        .ready   (ready),
        .rd_sop  (rd_sop),
        .rd_eop  (rd_eop),
        .rd_vld  (rd_vld),
        .rd_data (rd_data)
    );

    initial clk = 1'b0;
    always #(CLK_HALF) clk = ~clk;

    // collect output packets and watch the stream framing
    always @(posedge clk) begin
        if (rst_n && hydra_inst.enq.vld) begin
            enq_seen[hydra_inst.enq.desc.dest]++;
        end
        for (int p = 0; p < N_PORTS; p++) begin
            if (!rst_n) begin
                in_pkt[p]  = 1'b0;
                cur_len[p] = 0;
            end else if (rd_vld[p]) begin
                if (rd_sop[p]) begin
                    if (in_pkt[p]) begin
                        $display("t=%0t port %0d started a packet inside another", $time, p);
                        errors++;
                    end
                    in_pkt[p]  = 1'b1;
                    cur_len[p] = 0;
                end else if (!in_pkt[p]) begin
                    $display("t=%0t port %0d sent a word outside a packet", $time, p);
                    errors++;
                end
                rx_words[p].push_back(rd_data[p]);
                cur_len[p]++;
                if (rd_eop[p]) begin
                    rx_lens[p].push_back(cur_len[p]);
                    in_pkt[p] = 1'b0;
                end
            end else begin
                if (rd_sop[p] || rd_eop[p]) begin
                    $display("t=%0t port %0d raised a strobe without rd_vld", $time, p);
                    errors++;
                end
                if (in_pkt[p]) begin
                    $display("t=%0t port %0d dropped rd_vld inside a packet", $time, p);
                    errors++;
                    in_pkt[p] = 1'b0;
                end
            end
        end
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=0x%0h exp=0x%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic build_pkt(input int src, input int dest, input int prior, input int len);
        logic [31:0] r;
        pkt_buf[src].delete();
        for (int i = 0; i < len; i++) begin
            r = $urandom();
            if (i == 0) begin
                r[1:0] = dest[1:0];         // header dest
                r[3:2] = prior[1:0];        // header priority
            end
            pkt_buf[src].push_back(r[DATA_W-1:0]);
        end
    endtask

    task automatic expect_pkt(input int src, input int dest);
        for (int i = 0; i < pkt_buf[src].size(); i++) begin
            exp_words[dest].push_back(pkt_buf[src][i]);
        end
        exp_lens[dest].push_back(pkt_buf[src].size());
        enq_want[dest]++;
    endtask

    task automatic wait_pause(input int port, input logic level);
        int cycles;
        cycles = 0;
        while (pause[port] !== level && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (pause[port] !== level) begin
            $display("t=%0t pause[%0d] never went to %0d", $time, port, level);
            errors++;
        end
    endtask

    // called on a falling edge, gap_at > 0 puts one idle cycle before that word
    task automatic send_pkt(input int src, input int gap_at);
        int n;
        n = pkt_buf[src].size();
        wait_pause(src, 1'b0);
        for (int i = 0; i < n; i++) begin
            if (i == gap_at && i > 0) begin
                wr_sop[src] = 1'b0;
                wr_eop[src] = 1'b0;
                wr_vld[src] = 1'b0;
                @(negedge clk);
            end
            wr_sop[src]  = (i == 0);
            wr_eop[src]  = (i == n - 1);
            wr_vld[src]  = 1'b1;
            wr_data[src] = pkt_buf[src][i];
            @(negedge clk);
        end
        wr_sop[src] = 1'b0;
        wr_eop[src] = 1'b0;
        wr_vld[src] = 1'b0;
    endtask

    // every sent packet has been handed to its output queue
    task automatic wait_queued();
        int  cycles;
        bit  done;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            done = 1'b1;
            for (int p = 0; p < N_PORTS; p++) begin
                if (enq_seen[p] < enq_want[p]) done = 1'b0;
            end
            if (!done && cycles >= WAIT_LIMIT) begin
                $display("t=%0t sent packets never reached their output queues", $time);
                errors++;
                done = 1'b1;
            end
        end
    endtask

    task automatic wait_drain();
        int  cycles;
        bit  done;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            done = 1'b1;
            for (int p = 0; p < N_PORTS; p++) begin
                if (rx_lens[p].size() < exp_lens[p].size()) done = 1'b0;
            end
            if (!done && cycles >= WAIT_LIMIT) begin
                $display("t=%0t expected packets did not all arrive", $time);
                errors++;
                done = 1'b1;
            end
        end
    endtask

    task automatic compare_outputs();
        for (int p = 0; p < N_PORTS; p++) begin
            check_val($sformatf("packet count on rd_eop[%0d]", p),
                      rx_lens[p].size(), exp_lens[p].size());
            while (rx_lens[p].size() > 0 && exp_lens[p].size() > 0) begin
                check_val($sformatf("packet length on rd_vld[%0d]", p),
                          rx_lens[p].pop_front(), exp_lens[p].pop_front());
            end
            while (rx_words[p].size() > 0 && exp_words[p].size() > 0) begin
                check_val($sformatf("rd_data[%0d]", p),
                          32'(rx_words[p].pop_front()), 32'(exp_words[p].pop_front()));
            end
            rx_words[p].delete();
            rx_lens[p].delete();
            exp_words[p].delete();
            exp_lens[p].delete();
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            tests_ok++;
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d error(s)", tests_run, name, errors - errs_before);
        end
        ready = '1;
    endtask

    task automatic reset_values();
        int errs;
        errs = errors;
        check_val("pause", 32'(pause), 32'h0);
        check_val("rd_vld", 32'(rd_vld), 32'h0);
        check_val("rd_sop", 32'(rd_sop), 32'h0);
        check_val("rd_eop", 32'(rd_eop), 32'h0);
        finish_test("reset_values", errs);
    endtask

    task automatic single_packet();
        int errs;
        errs = errors;
        build_pkt(0, 2, 1, 6);
        expect_pkt(0, 2);
        send_pkt(0, 3);                     // one idle cycle inside the packet
        wait_drain();
        compare_outputs();
        finish_test("single_packet", errs);
    endtask

    task automatic strict_priority();
        int errs;
        errs = errors;
        ready[1] = 1'b0;
        build_pkt(0, 1, 0, 4);
        build_pkt(2, 1, 3, 5);
        send_pkt(0, 0);
        send_pkt(2, 0);
        expect_pkt(2, 1);                   // priority 3 overtakes
        expect_pkt(0, 1);
        wait_queued();
        ready[1] = 1'b1;
        wait_drain();
        compare_outputs();
        finish_test("strict_priority", errs);
    endtask

    task automatic arrival_order();
        int errs;
        errs = errors;
        ready[3] = 1'b0;
        build_pkt(2, 3, 2, 3);
        send_pkt(2, 0);
        expect_pkt(2, 3);
        build_pkt(1, 3, 2, 4);
        build_pkt(0, 3, 2, 4);
        fork
            send_pkt(1, 0);
            send_pkt(0, 0);
        join
        expect_pkt(0, 3);                   // same eop cycle, lower input first
        expect_pkt(1, 3);
        build_pkt(3, 3, 2, 2);
        send_pkt(3, 0);
        expect_pkt(3, 3);
        wait_queued();
        ready[3] = 1'b1;
        wait_drain();
        compare_outputs();
        finish_test("arrival_order", errs);
    endtask

    task automatic pause_backpressure();
        int errs;
        errs = errors;
        ready[0] = 1'b0;
        for (int k = 0; k < BANK_SLOTS; k++) begin
            build_pkt(3, 0, 1, 3 + k);
            send_pkt(3, 0);
            expect_pkt(3, 0);
        end
        wait_pause(3, 1'b1);                // every slot of bank 3 taken
        ready[0] = 1'b1;
        wait_drain();
        wait_pause(3, 1'b0);
        compare_outputs();
        finish_test("pause_backpressure", errs);
    endtask

    task automatic bank_contention();
        int errs;
        errs = errors;
        ready[0] = 1'b0;
        ready[2] = 1'b0;
        build_pkt(1, 0, 0, 7);
        send_pkt(1, 0);
        expect_pkt(1, 0);
        build_pkt(1, 2, 3, 5);
        send_pkt(1, 0);
        expect_pkt(1, 2);
        wait_queued();
        ready[0] = 1'b1;                    // both outputs go for bank 1 at once
        ready[2] = 1'b1;
        wait_drain();
        compare_outputs();
        finish_test("bank_contention", errs);
    endtask

    initial begin
        void'($urandom(83368));
        errors    = 0;
        tests_run = 0;
        tests_ok  = 0;
        rst_n     = 1'b0;
        wr_sop    = '0;
        wr_eop    = '0;
        wr_vld    = '0;
        wr_data   = '0;
        ready     = '1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_values();
        single_packet();
        strict_priority();
        arrival_order();
        pause_backpressure();
        bank_contention();

        $display("summary: %0d of %0d tests ok, %0d errors", tests_ok, tests_run, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: hydra.f
hdl/hydra_pkg.sv
hdl/sync_fifo.sv
hdl/rd_req_if.sv
hdl/packet_bank.sv
hdl/join_sequencer.sv
hdl/output_port.sv
hdl/hydra.sv
sim/hydra_props.sv
sim/hydra_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module hydra_tb -f hydra.f -o hydra_sim \
    && ./obj_dir/hydra_sim > sim.log 2>&1
grep -q "Simulation finished: PASS" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
